// File: verilog/busPkg.sv
package busPkg;

    // Program RAM depth in 32-bit words
    localparam int RAM_WORDS = 1024;
    localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS);

    // Memory mapped LED register
    localparam logic [31:0] LED_ADDR = 32'h4000_0000;

    // Framebuffer geometry, 64 x 64 pixels
    localparam int FB_X_BITS = 6;
    localparam int FB_Y_BITS = 6;
    localparam int FB_ADDR_BITS = FB_X_BITS + FB_Y_BITS;
    localparam int FB_PIXELS = 1 << FB_ADDR_BITS;

    // One byte of colour per pixel
    typedef logic [7:0] pixelT;

    // Processor memory bus
    // fetch high reads RAM at instrAddr, low reads at dataAddr
    typedef struct packed {
        logic [31:0] instrAddr;
        logic [31:0] dataAddr;
        logic [31:0] writeData;
        logic        dataWrite;
        logic        fetch;
    } cpuReqT;

endpackage

// File: verilog/bootPkg.sv
package bootPkg;

    // Global reset length after arstN is released
    localparam int RESET_CYCLES = 20;
    localparam int RESET_COUNT_BITS = $clog2(RESET_CYCLES + 1);

    // Card reader needs idle cycles between requests
    localparam int PACE_CYCLES = 4;
    localparam int PACE_COUNT_BITS = $clog2(PACE_CYCLES + 1);

    // Loader writes into program RAM
    localparam int LOAD_ADDR_BITS = $clog2(busPkg::RAM_WORDS);

    typedef enum logic [2:0] {
        IDLE, REQ_SIZE, WAIT_SIZE, REQ_WORD, WAIT_WORD, WRITE, RUN
    } loaderStateT;

    // Word request towards the card reader
    typedef struct packed {
        logic        read;
        logic [31:0] addr;
    } cardReqT;

    // Loader side of the program RAM write port
    typedef struct packed {
        logic                      write;
        logic [LOAD_ADDR_BITS-1:0] addr;
        logic [31:0]               data;
    } ramWriteT;

endpackage

// File: verilog/resetSequencer.sv
`timescale 1ns/100ps

module resetSequencer
    import bootPkg::*;
(
    input  logic clk_25mhz,
    input  logic arstN,
    output logic globalReset
);

    // Edges seen since arstN went high, saturates at RESET_CYCLES
    logic [RESET_COUNT_BITS-1:0] resetCount;
    logic countDone;

    assign countDone = (resetCount == RESET_COUNT_BITS'(RESET_CYCLES));

    always_ff @(posedge clk_25mhz or negedge arstN) begin
        if (!arstN) begin
            resetCount <= '0;
        end else if (!countDone) begin
            resetCount <= resetCount + 1'b1;
        end
    end

    // Asserts at once with arstN, releases on a clock edge
    assign globalReset = !countDone;

endmodule

// File: verilog/bootLoader.sv
`timescale 1ns/100ps

module bootLoader
    import bootPkg::*;
(
    input  logic        clk_25mhz,
    input  logic        arstN,
    input  logic        globalReset,
    output cardReqT     cardReq,
    input  logic [31:0] cardData,
    input  logic        cardDone,
    output ramWriteT    ramWr,
    output logic        cpuReset
);

    loaderStateT state;

    // Image words still to copy
    logic [31:0] remaining;
    // Card word held for the RAM write cycle
    logic [31:0] wordData;
    // Idle cycles since the last request or answer
    logic [PACE_COUNT_BITS-1:0] paceCount;
    logic paceDone;
    // RAM index of the word in flight
    logic [31:0] ramIndex;

    assign paceDone = (paceCount == PACE_COUNT_BITS'(PACE_CYCLES));

    // Card word k lands at RAM index k-1
    assign ramIndex = cardReq.addr - 32'd1;

    // One write in the cycle after cardDone
    assign ramWr.write = (state == WRITE);
    assign ramWr.addr = ramIndex[LOAD_ADDR_BITS-1:0];
    assign ramWr.data = wordData;

    // Pacing for the card reader
    always_ff @(posedge clk_25mhz or negedge arstN) begin
        if (!arstN) begin
            paceCount <= '0;
        end else if (globalReset || cardDone || cardReq.read) begin
            paceCount <= '0;
        end else if (!paceDone) begin
            paceCount <= paceCount + 1'b1;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (state == WAIT_WORD && cardDone) begin
            wordData <= cardData;
        end
    end

    always_ff @(posedge clk_25mhz or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
            cardReq <= '0;
            remaining <= '0;
            cpuReset <= 1'b1;
        end else if (globalReset) begin
            state <= IDLE;
            cardReq <= '0;
            remaining <= '0;
            cpuReset <= 1'b1;
        end else begin
            // Strobe lasts one cycle
            cardReq.read <= 1'b0;
            // Processor leaves reset one edge after RUN
            cpuReset <= (state != RUN);
            case (state)
                IDLE: begin
                    state <= REQ_SIZE;
                end
                REQ_SIZE: begin
                    if (paceDone) begin
                        cardReq.read <= 1'b1;
                        state <= WAIT_SIZE;
                    end
                end
                WAIT_SIZE: begin
                    // Word 0 is the image length
                    if (cardDone) begin
                        remaining <= cardData;
                        cardReq.addr <= 32'd1;
                        state <= (cardData == 32'd0) ? RUN : REQ_WORD;
                    end
                end
                REQ_WORD: begin
                    if (paceDone) begin
                        cardReq.read <= 1'b1;
                        state <= WAIT_WORD;
                    end
                end
                WAIT_WORD: begin
                    if (cardDone) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    remaining <= remaining - 32'd1;
                    cardReq.addr <= cardReq.addr + 32'd1;
                    state <= (remaining == 32'd1) ? RUN : REQ_WORD;
                end
                RUN: begin
                    state <= RUN;   // until the next reset
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/simpleDualRam.sv
`timescale 1ns/100ps

module simpleDualRam #(
    parameter type wordT = logic [31:0],
    parameter int DEPTH = 1024
) (
    input  logic                     clk_25mhz,
    input  logic                     write,
    input  logic [$clog2(DEPTH)-1:0] writeAddr,
    input  wordT                     writeData,
    input  logic [$clog2(DEPTH)-1:0] readAddr,
    output wordT                     readData
);

    // Storage array, maps onto block RAM
    wordT mem [DEPTH];

    // Write port
    always_ff @(posedge clk_25mhz) begin
        if (write) begin
            mem[writeAddr] <= writeData;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk_25mhz) begin
        readData <= mem[readAddr];
    end

endmodule

// File: verilog/busDecoder.sv
`timescale 1ns/100ps

module busDecoder
    import busPkg::*;
    import bootPkg::*;
(
    input  logic                     clk_25mhz,
    input  logic                     arstN,
    input  logic                     globalReset,
    input  logic                     cpuReset,
    input  ramWriteT                 ramWr,
    input  cpuReqT                   cpuReq,
    output logic                     progWrite,
    output logic [RAM_ADDR_BITS-1:0] progAddr,
    output logic [31:0]              progWriteData,
    input  logic [31:0]              progReadData,
    output logic [31:0]              cpuReadData,
    output logic                     fbWrite,
    output logic [FB_ADDR_BITS-1:0]  fbWriteAddr,
    output pixelT                    fbWriteData,
    output logic [7:0]               leds
);

    logic selRam;
    logic selFb;
    logic selLed;
    logic cpuWrite;
    logic [RAM_ADDR_BITS-1:0] cpuRamAddr;

    // Address regions
    assign selFb = cpuReq.dataAddr[31];
    assign selRam = !cpuReq.dataAddr[31] && !cpuReq.dataAddr[30];
    assign selLed = (cpuReq.dataAddr == LED_ADDR);

    // Processor writes count only once the loader is done
    assign cpuWrite = !cpuReset && cpuReq.dataWrite;

    // Single RAM address, instruction fetch wins
    assign cpuRamAddr = cpuReq.fetch ? cpuReq.instrAddr[RAM_ADDR_BITS-1:0]
                                     : cpuReq.dataAddr[RAM_ADDR_BITS-1:0];

    // Loader owns program RAM while the processor is held in reset
    assign progWrite = cpuReset ? ramWr.write : (cpuWrite && selRam && !cpuReq.fetch);
    assign progAddr = cpuReset ? ramWr.addr : cpuRamAddr;
    assign progWriteData = cpuReset ? ramWr.data : cpuReq.writeData;

    // RAM already registers the read
    assign cpuReadData = progReadData;

    // Pixel address is y in the high bits, x in the low bits
    assign fbWrite = cpuWrite && selFb;
    assign fbWriteAddr = {cpuReq.dataAddr[24 +: FB_Y_BITS], cpuReq.dataAddr[16 +: FB_X_BITS]};
    assign fbWriteData = cpuReq.writeData[7:0];

    // LED register
    always_ff @(posedge clk_25mhz or negedge arstN) begin
        if (!arstN) begin
            leds <= '0;
        end else if (globalReset) begin
            leds <= '0;
        end else if (cpuWrite && selLed) begin
            leds <= cpuReq.writeData[7:0];
        end
    end

endmodule

// File: verilog/bootTop.sv
`timescale 1ns/100ps

module bootTop
    import busPkg::*;
    import bootPkg::*;
(
    input  logic                 clk_25mhz,
    input  logic                 arstN,
    output cardReqT              cardReq,
    input  logic [31:0]          cardData,
    input  logic                 cardDone,
    input  cpuReqT               cpuReq,
    output logic [31:0]          cpuReadData,
    output logic                 cpuReset,
    input  logic [FB_X_BITS-1:0] pixelX,
    input  logic [FB_Y_BITS-1:0] pixelY,
    output pixelT                pixelColor,
    output logic [7:0]           leds
);

    logic globalReset;
    ramWriteT ramWr;

    // Program RAM port
    logic progWrite;
    logic [RAM_ADDR_BITS-1:0] progAddr;
    logic [31:0] progWriteData;
    logic [31:0] progReadData;

    // Framebuffer write port
    logic fbWrite;
    logic [FB_ADDR_BITS-1:0] fbWriteAddr;
    pixelT fbWriteData;

    resetSequencer resetSeq (
        .clk_25mhz   (clk_25mhz),
        .arstN       (arstN),
        .globalReset (globalReset)
    );

    bootLoader loader (
        .clk_25mhz   (clk_25mhz),
        .arstN       (arstN),
        .globalReset (globalReset),
        .cardReq     (cardReq),
        .cardData    (cardData),
        .cardDone    (cardDone),
        .ramWr       (ramWr),
        .cpuReset    (cpuReset)
    );

    busDecoder decoder (
        .clk_25mhz     (clk_25mhz),
        .arstN         (arstN),
        .globalReset   (globalReset),
        .cpuReset      (cpuReset),
        .ramWr         (ramWr),
        .cpuReq        (cpuReq),
        .progWrite     (progWrite),
        .progAddr      (progAddr),
        .progWriteData (progWriteData),
        .progReadData  (progReadData),
        .cpuReadData   (cpuReadData),
        .fbWrite       (fbWrite),
        .fbWriteAddr   (fbWriteAddr),
        .fbWriteData   (fbWriteData),
        .leds          (leds)
    );

    // Program words, one shared address for read and write
    simpleDualRam #(.wordT(logic [31:0]), .DEPTH(RAM_WORDS)) progRam (
        .clk_25mhz (clk_25mhz),
        .write     (progWrite),
        .writeAddr (progAddr),
        .writeData (progWriteData),
        .readAddr  (progAddr),
        .readData  (progReadData)
    );

    // Pixels, read side belongs to the display scanner
    simpleDualRam #(.wordT(pixelT), .DEPTH(FB_PIXELS)) frameRam (
        .clk_25mhz (clk_25mhz),
        .write     (fbWrite),
        .writeAddr (fbWriteAddr),
        .writeData (fbWriteData),
        .readAddr  ({pixelY, pixelX}),
        .readData  (pixelColor)
    );

endmodule

// File: verif/cardImage.svh
// Number of program words that follow the length word
localparam int IMAGE_WORDS = 12;

// Card word k, word 0 carries the image length
function automatic logic [31:0] cardWord(input int k);
    logic [31:0] kw;
    kw = 32'(k);
    if (k == 0) begin
        return 32'(IMAGE_WORDS);
    end
    // Fixed mix so that neighbouring words differ in many bits
    return (kw * 32'h9E37_79B1) ^ (kw << 8) ^ 32'h5A5A_0000;
endfunction

// File: verif/bootAssert.sv
`timescale 1ns/100ps

module bootAssert
    import busPkg::*;
    import bootPkg::*;
(
    input logic                 clk_25mhz,
    input logic                 arstN,
    input cardReqT              cardReq,
    input logic                 cardDone,
    input cpuReqT               cpuReq,
    input logic [31:0]          cpuReadData,
    input logic                 cpuReset,
    input logic [FB_X_BITS-1:0] pixelX,
    input logic [FB_Y_BITS-1:0] pixelY,
    input pixelT                pixelColor,
    input logic [7:0]           leds
);

    `include "cardImage.svh"

    // Failed assertions so far, read by the testbench
    int failCount = 0;

    // Card protocol bookkeeping
    int sinceRelease;
    int reqCount;
    int doneCount;
    int gapCount;
    logic pending;

    // Reference memories built from the bus rules
    logic [31:0] ramModel [RAM_WORDS];
    logic ramKnown [RAM_WORDS];
    pixelT fbModel [FB_PIXELS];
    logic fbKnown [FB_PIXELS];
    logic [31:0] expRead;
    logic expReadValid;
    pixelT expPixel;
    logic expPixelValid;
    logic [7:0] ledModel;

    logic [RAM_ADDR_BITS-1:0] ramIdx;
    logic [FB_ADDR_BITS-1:0] fbIdx;
    logic ramWriteHit;
    logic fbWriteHit;

    assign ramIdx = cpuReq.fetch ? cpuReq.instrAddr[RAM_ADDR_BITS-1:0]
                                 : cpuReq.dataAddr[RAM_ADDR_BITS-1:0];
    assign fbIdx = {cpuReq.dataAddr[29:24], cpuReq.dataAddr[21:16]};
    assign ramWriteHit = !cpuReset && cpuReq.dataWrite && !cpuReq.fetch
                         && !cpuReq.dataAddr[31] && !cpuReq.dataAddr[30];
    assign fbWriteHit = !cpuReset && cpuReq.dataWrite && cpuReq.dataAddr[31];

    // Boot image lands at index k-1
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            ramKnown[i] = (i < IMAGE_WORDS);
            ramModel[i] = (i < IMAGE_WORDS) ? cardWord(i + 1) : 32'h0;
        end
        for (int i = 0; i < FB_PIXELS; i++) begin
            fbKnown[i] = 1'b0;
            fbModel[i] = 8'h00;
        end
    end

    always @(posedge clk_25mhz or negedge arstN) begin
        if (!arstN) begin
            sinceRelease <= 0;
            reqCount <= 0;
            doneCount <= 0;
            gapCount <= 1000;
            pending <= 1'b0;
            ledModel <= 8'h00;
            expReadValid <= 1'b0;
            expPixelValid <= 1'b0;
        end else begin
            if (sinceRelease < 1000) begin
                sinceRelease <= sinceRelease + 1;
            end
            if (cardReq.read) begin
                reqCount <= reqCount + 1;
                pending <= 1'b1;
            end else if (cardDone) begin
                pending <= 1'b0;
            end
            if (cardDone) begin
                doneCount <= doneCount + 1;
                gapCount <= 0;
            end else if (gapCount < 1000) begin
                gapCount <= gapCount + 1;
            end
            // Read sees the old contents on a same-cycle write
            expRead <= ramModel[ramIdx];
            expReadValid <= !cpuReset && ramKnown[ramIdx];
            if (ramWriteHit) begin
                ramModel[ramIdx] <= cpuReq.writeData;
                ramKnown[ramIdx] <= 1'b1;
            end
            expPixel <= fbModel[{pixelY, pixelX}];
            expPixelValid <= fbKnown[{pixelY, pixelX}];
            if (fbWriteHit) begin
                fbModel[fbIdx] <= cpuReq.writeData[7:0];
                fbKnown[fbIdx] <= 1'b1;
            end
            if (!cpuReset && cpuReq.dataWrite && cpuReq.dataAddr == LED_ADDR) begin
                ledModel <= cpuReq.writeData[7:0];
            end
        end
    end

    resetOutputs: assert property (@(posedge clk_25mhz)
        !arstN |-> cpuReset && leds == 8'h00 && !cardReq.read)
        else begin
            $error("Control outputs wrong while arstN is low");
            failCount = failCount + 1;
        end

    noEarlyRequest: assert property (@(posedge clk_25mhz)
        cardReq.read |-> sinceRelease > RESET_CYCLES)
        else begin
            $error("Card request inside the reset window");
            failCount = failCount + 1;
        end

    requestOrder: assert property (@(posedge clk_25mhz)
        cardReq.read |-> cardReq.addr == 32'(reqCount) && reqCount <= IMAGE_WORDS)
        else begin
            $error("Mismatch cardReq.addr got %h expected %h", cardReq.addr, reqCount);
            failCount = failCount + 1;
        end

    singleOutstanding: assert property (@(posedge clk_25mhz)
        cardReq.read |-> !pending)
        else begin
            $error("Second card request before cardDone");
            failCount = failCount + 1;
        end

    requestPacing: assert property (@(posedge clk_25mhz)
        cardReq.read |-> gapCount >= PACE_CYCLES)
        else begin
            $error("Card request too soon after cardDone");
            failCount = failCount + 1;
        end

    bootComplete: assert property (@(posedge clk_25mhz)
        $fell(cpuReset) |-> doneCount == IMAGE_WORDS + 1)
        else begin
            $error("Mismatch doneCount got %h expected %h", doneCount, IMAGE_WORDS + 1);
            failCount = failCount + 1;
        end

    ramReadData: assert property (@(posedge clk_25mhz)
        expReadValid |-> cpuReadData == expRead)
        else begin
            $error("Mismatch cpuReadData got %h expected %h", cpuReadData, expRead);
            failCount = failCount + 1;
        end

    pixelReadData: assert property (@(posedge clk_25mhz)
        expPixelValid |-> pixelColor == expPixel)
        else begin
            $error("Mismatch pixelColor got %h expected %h", pixelColor, expPixel);
            failCount = failCount + 1;
        end

    ledValue: assert property (@(posedge clk_25mhz) leds == ledModel)
        else begin
            $error("Mismatch leds got %h expected %h", leds, ledModel);
            failCount = failCount + 1;
        end

endmodule

bind bootTop bootAssert checks (.*);

// File: verif/bootTb.sv
`timescale 1ns/100ps

module bootTb
    import busPkg::*;
    import bootPkg::*;
;

    `include "cardImage.svh"

    logic clk_25mhz = 1'b0;
    logic arstN = 1'b1;
    cardReqT cardReq;
    logic [31:0] cardData;
    logic cardDone;
    cpuReqT cpuReq;
    logic [31:0] cpuReadData;
    logic cpuReset;
    logic [FB_X_BITS-1:0] pixelX;
    logic [FB_Y_BITS-1:0] pixelY;
    pixelT pixelColor;
    logic [7:0] leds;

    int testsPassed = 0;
    int testsFailed = 0;
    int failsBefore = 0;

    // 25 MHz
    always #20 clk_25mhz = !clk_25mhz;

    bootTop uut (.*);

    // Card reader answers each strobe once after 1 to 8 cycles
    always begin : cardReader
        int latency;
        logic [31:0] addr;
        @(posedge clk_25mhz);
        if (arstN && cardReq.read) begin
            latency = int'($urandom_range(8, 1));
            addr = cardReq.addr;
            repeat (latency - 1) @(posedge clk_25mhz);
            cardData <= cardWord(int'(addr));
            cardDone <= 1'b1;
            @(posedge clk_25mhz);
            cardDone <= 1'b0;
        end
    end

    task automatic busCycle(input logic [31:0] instrAddr, input logic [31:0] dataAddr,
                            input logic [31:0] data, input logic write, input logic fetch);
        @(posedge clk_25mhz);
        cpuReq <= '{instrAddr: instrAddr, dataAddr: dataAddr, writeData: data,
                    dataWrite: write, fetch: fetch};
    endtask

    task automatic busIdle(input int cycles);
        @(posedge clk_25mhz);
        cpuReq <= '0;
        repeat (cycles) @(posedge clk_25mhz);
    endtask

    task automatic finishTest(input string name);
        if (uut.checks.failCount == failsBefore) begin
            testsPassed++;
            $display("Test %s: ok", name);
        end else begin
            testsFailed++;
            $display("Test %s: FAILED with %0d assertion errors", name,
                     uut.checks.failCount - failsBefore);
        end
        failsBefore = uut.checks.failCount;
    endtask

    task automatic abortRun(input string reason);
        $display("Timeout: %s", reason);
        $display("Verification failed");
        $finish;
    endtask

    // Processor and scanner traffic once the image is loaded
    task automatic runBusTests();
        logic [31:0] data;
        logic [31:0] fbAddr;
        for (int k = 1; k <= IMAGE_WORDS; k++) begin
            busCycle(32'(k - 1), 32'h0, 32'h0, 1'b0, 1'b1);
        end
        busIdle(3);
        finishTest("boot completion");

        for (int i = 0; i < 8; i++) begin
            data = $urandom;
            busCycle(32'h0, 32'(100 + 7 * i), data, 1'b1, 1'b0);
            busCycle(32'h0, 32'(100 + 7 * i), 32'h0, 1'b0, 1'b0);
        end
        busIdle(3);
        finishTest("ram data path");

        for (int i = 0; i < 8; i++) begin
            data = $urandom;
            fbAddr = 32'h8000_0000 | (32'(3 * i + 1) << 24) | (32'(5 * i + 2) << 16);
            busCycle(32'h0, fbAddr, data, 1'b1, 1'b0);
            // RAM at the low address bits stays as it was
            busCycle(32'h0, fbAddr, 32'h0, 1'b0, 1'b0);
            @(posedge clk_25mhz);
            pixelY <= 6'(3 * i + 1);
            pixelX <= 6'(5 * i + 2);
        end
        busIdle(3);
        finishTest("framebuffer");

        for (int i = 0; i < 4; i++) begin
            busCycle(32'h0, LED_ADDR, $urandom, 1'b1, 1'b0);
            busCycle(32'h0, LED_ADDR + 32'h4, $urandom, 1'b1, 1'b0);
            busCycle(32'h0, 32'h4000_1000, $urandom, 1'b1, 1'b0);
            busIdle(1);
        end
        busIdle(3);
        finishTest("led register");
    endtask

    initial begin : stimulus
        logic seen;
        void'($urandom(32'hea3922f5));
        // Reset goes low at time zero
        arstN <= 1'b0;
        cardData = '0;
        cardDone = 1'b0;
        cpuReq = '0;
        pixelX = '0;
        pixelY = '0;
        repeat (4) @(posedge clk_25mhz);
        arstN <= 1'b1;

        // First card request ends the reset phase
        seen = 1'b0;
        for (int i = 0; i < 200 && !seen; i++) begin
            @(posedge clk_25mhz);
            seen = cardReq.read;
        end
        if (!seen) begin
            abortRun("no card request after reset");
        end else begin
            @(posedge clk_25mhz);
            finishTest("reset");

            seen = 1'b0;
            for (int i = 0; i < 2000 && !seen; i++) begin
                @(posedge clk_25mhz);
                seen = !cpuReset;
            end
            if (!seen) begin
                abortRun("cpuReset never released");
            end else begin
                @(posedge clk_25mhz);
                finishTest("card protocol");
                runBusTests();

                $display("Tests run: %0d, passed: %0d, failed: %0d",
                         testsPassed + testsFailed, testsPassed, testsFailed);
                if (testsFailed == 0) begin
                    $display("Verification passed");
                end else begin
                    $display("Verification failed");
                end
                $finish;
            end
        end
    end

endmodule

// File: sources.f
+incdir+verif
verilog/busPkg.sv
verilog/bootPkg.sv
verilog/resetSequencer.sv
verilog/bootLoader.sv
verilog/simpleDualRam.sv
verilog/busDecoder.sv
verilog/bootTop.sv
verif/bootAssert.sv
verif/bootTb.sv

// File: run.sh
#!/bin/sh
# Build and run the boot subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module bootTb -Mdir obj_dir -f sources.f
./obj_dir/VbootTb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -q "Verification passed" sim.log; then
    exit 0
else
    exit 1
fi
